/* verilog/phold_config.svh */
`ifndef PHOLD_CONFIG_SVH
`define PHOLD_CONFIG_SVH

// processing cores served by the scheduler
`define PHOLD_NUM_CORE 4
`define PHOLD_CORE_ID_W 2

// logical process id width
`define PHOLD_LP_W 8

// timestamp width, also used for gvt and sim_end
`define PHOLD_TIME_W 16

// unused low bits of a 32-bit event message
`define PHOLD_MSG_PAD_W 7

// event queue entries and occupancy count width
`define PHOLD_QUEUE_DEPTH 16
`define PHOLD_QCOUNT_W 5

// width of each run statistics counter
`define PHOLD_STAT_W 32

`endif

/* verilog/phold_pkg.sv */
`default_nettype none

`include "phold_config.svh"

package phold_pkg;

   // event message, 32 bits
   // a null message is anti set with lp and time both zero
   typedef struct packed {
      logic                         anti;
      logic [`PHOLD_LP_W-1:0]       lp;
      logic [`PHOLD_TIME_W-1:0]     ts;
      logic [`PHOLD_MSG_PAD_W-1:0]  pad;
   } event_msg_t;

   // run control states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_INIT,
      ST_RUNNING,
      ST_FINISHED
   } run_state_t;

   typedef struct packed {
      logic done;
      logic overflow;
      logic blocked;
   } sched_status_t;

   typedef struct packed {
      logic [`PHOLD_STAT_W-1:0] cycles;
      logic [`PHOLD_STAT_W-1:0] events;
      logic [`PHOLD_STAT_W-1:0] antimsgs;
   } sched_stats_t;

endpackage

`default_nettype wire

/* verilog/rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phold_config.svh"

module rr_arbiter (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [`PHOLD_NUM_CORE-1:0]   req,
   output logic                         grant_vld,
   output logic [`PHOLD_CORE_ID_W-1:0]  grant_id,
   input  logic                         advance
);

   // index of the last core whose grant was used
   logic [`PHOLD_CORE_ID_W-1:0] last_id;

   // search starts one past the last winner and wraps around
   always_comb begin
      logic [`PHOLD_CORE_ID_W-1:0] idx;
      idx       = last_id;
      grant_vld = 1'b0;
      grant_id  = last_id;
      for (int i = 1; i <= `PHOLD_NUM_CORE; i++) begin
         idx = last_id + `PHOLD_CORE_ID_W'(i);
         if (!grant_vld && req[idx]) begin
            grant_vld = 1'b1;
            grant_id  = idx;
         end
      end
   end

   // core 0 gets the first turn after reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last_id <= '1;
      end else if (advance) begin
         last_id <= grant_id;
      end
   end

endmodule

`default_nettype wire

/* verilog/event_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phold_config.svh"

module event_queue import phold_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        enq,
   input  logic                        deq,
   input  event_msg_t                  enq_msg,
   output event_msg_t                  head_msg,
   output logic                        empty,
   output logic                        full,
   output logic [`PHOLD_QCOUNT_W-1:0]  count
);

   event_msg_t                    q_mem [`PHOLD_QUEUE_DEPTH];
   logic [`PHOLD_QCOUNT_W-1:0]    q_count;
   logic [`PHOLD_QUEUE_DEPTH-1:0] stay;

   // time first, then inverted anti flag so anti-messages win ties
   function automatic logic [`PHOLD_TIME_W:0] sort_key(input event_msg_t m);
      return {m.ts, ~m.anti};
   endfunction

   assign empty    = (q_count == '0);
   assign full     = (q_count == `PHOLD_QCOUNT_W'(`PHOLD_QUEUE_DEPTH));
   assign count    = q_count;
   assign head_msg = q_mem[0];

   // entries that sort at or before the new one keep their slot
   // thermometer code because the array is always sorted
   always_comb begin
      for (int i = 0; i < `PHOLD_QUEUE_DEPTH; i++) begin
         stay[i] = (i < q_count) && (sort_key(q_mem[i]) <= sort_key(enq_msg));
      end
   end

   always_ff @(posedge clk) begin
      if (enq && !full) begin
         if (!stay[0]) begin
            q_mem[0] <= enq_msg;
         end
         for (int i = 1; i < `PHOLD_QUEUE_DEPTH; i++) begin
            if (!stay[i]) begin
               // first larger slot takes the new event, the rest move down
               if (stay[i-1]) begin
                  q_mem[i] <= enq_msg;
               end else begin
                  q_mem[i] <= q_mem[i-1];
               end
            end
         end
      end else if (deq && !empty) begin
         for (int i = 0; i < `PHOLD_QUEUE_DEPTH - 1; i++) begin
            q_mem[i] <= q_mem[i+1];
         end
      end
   end

   // enqueue into a full queue drops the event
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q_count <= '0;
      end else if (enq) begin
         if (!full) begin
            q_count <= q_count + 1'b1;
         end
      end else if (deq && !empty) begin
         q_count <= q_count - 1'b1;
      end
   end

endmodule

`default_nettype wire

/* verilog/event_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phold_config.svh"

module event_dispatch import phold_pkg::*; (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  run_state_t                           run_state,
   input  logic                                 block_dispatch,
   input  logic [7:0]                           num_init_events,
   input  logic [`PHOLD_LP_W-1:0]               lp_mask,
   input  logic [`PHOLD_NUM_CORE-1:0]           core_ready,
   input  logic [`PHOLD_NUM_CORE-1:0]           result_vld,
   input  event_msg_t [`PHOLD_NUM_CORE-1:0]     result_msg,
   input  event_msg_t                           head_msg,
   input  logic                                 q_empty,
   output logic                                 enq,
   output logic                                 deq,
   output event_msg_t                           enq_msg,
   output logic [`PHOLD_NUM_CORE-1:0]           dispatch_vld,
   output event_msg_t                           dispatch_msg,
   output logic [`PHOLD_CORE_ID_W-1:0]          dispatch_id,
   output logic [`PHOLD_NUM_CORE-1:0]           result_ack,
   output logic                                 init_done
);

   logic                        busy;
   logic [7:0]                  init_cnt;
   logic                        in_init;
   logic                        in_running;
   logic                        rcv_vld;
   logic                        send_vld;
   logic [`PHOLD_CORE_ID_W-1:0] rcv_id;
   logic [`PHOLD_CORE_ID_W-1:0] send_id;
   logic                        take_result;
   logic                        rcv_null;
   event_msg_t                  rcv_msg;
   event_msg_t                  init_msg;

   assign in_init    = (run_state == ST_INIT);
   assign in_running = (run_state == ST_RUNNING);
   assign init_done  = (init_cnt == num_init_events);

   // initial event i targets lp (i & lp_mask) at time zero
   assign init_msg = '{anti: 1'b0, lp: init_cnt & lp_mask, ts: '0, pad: '0};

   assign rcv_msg  = result_msg[rcv_id];
   assign rcv_null = rcv_msg.anti && (rcv_msg.lp == '0) && (rcv_msg.ts == '0);

   // results are taken on free cycles, nulls are acked but never queued
   assign take_result = in_running && !busy && rcv_vld;
   assign enq = !busy && ((in_init && !init_done) || (take_result && !rcv_null));
   assign enq_msg = in_init ? init_msg : rcv_msg;

   // dispatch only when no enqueue claims this cycle
   assign deq = in_running && !busy && !enq && !q_empty && send_vld && !block_dispatch;

   assign dispatch_msg = head_msg;
   assign dispatch_id  = send_id;

   always_comb begin
      result_ack   = '0;
      dispatch_vld = '0;
      if (take_result) begin
         result_ack[rcv_id] = 1'b1;
      end
      if (deq) begin
         dispatch_vld[send_id] = 1'b1;
      end
   end

   // each queue operation is followed by one idle cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy     <= 1'b0;
         init_cnt <= '0;
      end else begin
         busy <= enq || deq;
         if (in_init && enq) begin
            init_cnt <= init_cnt + 1'b1;
         end
      end
   end

   // receive side, new events and nulls from the cores
   rr_arbiter u_rcv_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (result_vld),
      .grant_vld (rcv_vld),
      .grant_id  (rcv_id),
      .advance   (take_result)
   );

   // send side, idle cores waiting for work
   rr_arbiter u_send_arb (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (core_ready),
      .grant_vld (send_vld),
      .grant_id  (send_id),
      .advance   (deq)
   );

endmodule

`default_nettype wire

/* verilog/gvt_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phold_config.svh"

module gvt_tracker import phold_pkg::*; (
   input  logic                         clk,
   input  logic                         rst_n,
   input  run_state_t                   run_state,
   input  logic [`PHOLD_NUM_CORE-1:0]   dispatch_vld,
   input  logic [`PHOLD_CORE_ID_W-1:0]  dispatch_id,
   input  event_msg_t                   dispatch_msg,
   input  logic [`PHOLD_NUM_CORE-1:0]   result_ack,
   input  event_msg_t                   head_msg,
   input  logic                         q_empty,
   output logic [`PHOLD_NUM_CORE-1:0]   core_active,
   output logic [`PHOLD_TIME_W-1:0]     gvt
);

   logic [`PHOLD_NUM_CORE-1:0] active_q;
   logic [`PHOLD_TIME_W-1:0]   flight_ts [`PHOLD_NUM_CORE];
   logic                       min_vld;
   logic [`PHOLD_TIME_W-1:0]   min_ts;

   assign core_active = active_q;

   // a core is busy from its dispatch until its result is acked
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         active_q <= '0;
      end else begin
         active_q <= (active_q & ~result_ack) | dispatch_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (|dispatch_vld) begin
         flight_ts[dispatch_id] <= dispatch_msg.ts;
      end
   end

   // lowest of queue head and in-flight times
   always_comb begin
      min_vld = !q_empty;
      min_ts  = head_msg.ts;
      for (int i = 0; i < `PHOLD_NUM_CORE; i++) begin
         if (active_q[i] && (!min_vld || flight_ts[i] < min_ts)) begin
            min_vld = 1'b1;
            min_ts  = flight_ts[i];
         end
      end
   end

   // gvt holds when nothing is queued or in flight
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (run_state == ST_RUNNING && min_vld) begin
         gvt <= min_ts;
      end
   end

endmodule

`default_nettype wire

/* verilog/sim_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phold_config.svh"

module sim_control import phold_pkg::*; (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        init_done,
   input  logic [`PHOLD_TIME_W-1:0]    gvt,
   input  logic [`PHOLD_TIME_W-1:0]    sim_end,
   input  logic [`PHOLD_NUM_CORE-1:0]  core_active,
   input  logic                        enq,
   input  logic                        q_full,
   input  logic [`PHOLD_NUM_CORE-1:0]  dispatch_vld,
   input  event_msg_t                  dispatch_msg,
   output run_state_t                  run_state,
   output logic                        block_dispatch,
   output sched_status_t               status,
   output sched_stats_t                stats
);

   run_state_t   state_q;
   run_state_t   state_d;
   logic         done_q;
   logic         ovf_q;
   logic         ovf_evt;
   logic         past_end;
   sched_stats_t stats_q;

   assign ovf_evt  = enq && q_full;
   assign past_end = (gvt > sim_end);

   assign run_state      = state_q;
   assign block_dispatch = past_end;
   assign status         = '{done: done_q, overflow: ovf_q, blocked: past_end};
   assign stats          = stats_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: state_d = ST_INIT;
         ST_INIT: begin
            if (ovf_evt) begin
               state_d = ST_FINISHED;
            end else if (init_done) begin
               state_d = ST_RUNNING;
            end
         end
         ST_RUNNING: begin
            // ends on a lost event, or past end time once all cores drain
            if (ovf_evt || (past_end && !(|core_active))) begin
               state_d = ST_FINISHED;
            end
         end
         ST_FINISHED: state_d = ST_FINISHED;
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ST_IDLE;
         done_q  <= 1'b0;
         ovf_q   <= 1'b0;
         stats_q <= '0;
      end else begin
         state_q <= state_d;
         done_q  <= (state_d == ST_FINISHED);
         if (ovf_evt) begin
            ovf_q <= 1'b1;
         end
         if (state_q == ST_RUNNING) begin
            stats_q.cycles <= stats_q.cycles + 1'b1;
         end
         if (|dispatch_vld) begin
            stats_q.events <= stats_q.events + 1'b1;
            if (dispatch_msg.anti) begin
               stats_q.antimsgs <= stats_q.antimsgs + 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/phold_sched.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phold_config.svh"

module phold_sched import phold_pkg::*; (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic [`PHOLD_TIME_W-1:0]             sim_end,
   input  logic [7:0]                           num_init_events,
   input  logic [`PHOLD_LP_W-1:0]               lp_mask,
   input  logic [`PHOLD_NUM_CORE-1:0]           core_ready,
   input  logic [`PHOLD_NUM_CORE-1:0]           result_vld,
   input  event_msg_t [`PHOLD_NUM_CORE-1:0]     result_msg,
   output logic [`PHOLD_NUM_CORE-1:0]           dispatch_vld,
   output event_msg_t                           dispatch_msg,
   output logic [`PHOLD_NUM_CORE-1:0]           result_ack,
   output logic [`PHOLD_TIME_W-1:0]             gvt,
   output sched_status_t                        status,
   output sched_stats_t                         stats
);

   run_state_t                  run_state;
   logic                        block_dispatch;
   logic                        init_done;
   logic                        enq;
   logic                        deq;
   event_msg_t                  enq_msg;
   event_msg_t                  head_msg;
   logic                        q_empty;
   logic                        q_full;
   logic [`PHOLD_CORE_ID_W-1:0] dispatch_id;
   logic [`PHOLD_NUM_CORE-1:0]  core_active;

   event_dispatch u_dispatch (
      .clk             (clk),
      .rst_n           (rst_n),
      .run_state       (run_state),
      .block_dispatch  (block_dispatch),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .core_ready      (core_ready),
      .result_vld      (result_vld),
      .result_msg      (result_msg),
      .head_msg        (head_msg),
      .q_empty         (q_empty),
      .enq             (enq),
      .deq             (deq),
      .enq_msg         (enq_msg),
      .dispatch_vld    (dispatch_vld),
      .dispatch_msg    (dispatch_msg),
      .dispatch_id     (dispatch_id),
      .result_ack      (result_ack),
      .init_done       (init_done)
   );

   event_queue u_queue (
      .clk      (clk),
      .rst_n    (rst_n),
      .enq      (enq),
      .deq      (deq),
      .enq_msg  (enq_msg),
      .head_msg (head_msg),
      .empty    (q_empty),
      .full     (q_full),
      .count    ()
   );

   gvt_tracker u_gvt (
      .clk          (clk),
      .rst_n        (rst_n),
      .run_state    (run_state),
      .dispatch_vld (dispatch_vld),
      .dispatch_id  (dispatch_id),
      .dispatch_msg (dispatch_msg),
      .result_ack   (result_ack),
      .head_msg     (head_msg),
      .q_empty      (q_empty),
      .core_active  (core_active),
      .gvt          (gvt)
   );

   sim_control u_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .init_done      (init_done),
      .gvt            (gvt),
      .sim_end        (sim_end),
      .core_active    (core_active),
      .enq            (enq),
      .q_full         (q_full),
      .dispatch_vld   (dispatch_vld),
      .dispatch_msg   (dispatch_msg),
      .run_state      (run_state),
      .block_dispatch (block_dispatch),
      .status         (status),
      .stats          (stats)
   );

endmodule

`default_nettype wire

/* tb/tb_phold_sched.sv */
`timescale 1ns/1ps
`default_nettype none

`include "phold_config.svh"

module tb_phold_sched import phold_pkg::*;;

   logic                                 clk;
   logic                                 rst_n;
   logic [`PHOLD_TIME_W-1:0]             sim_end;
   logic [7:0]                           num_init_events;
   logic [`PHOLD_LP_W-1:0]               lp_mask;
   logic [`PHOLD_NUM_CORE-1:0]           core_ready;
   logic [`PHOLD_NUM_CORE-1:0]           result_vld;
   event_msg_t [`PHOLD_NUM_CORE-1:0]     result_msg;
   logic [`PHOLD_NUM_CORE-1:0]           dispatch_vld;
   event_msg_t                           dispatch_msg;
   logic [`PHOLD_NUM_CORE-1:0]           result_ack;
   logic [`PHOLD_TIME_W-1:0]             gvt;
   sched_status_t                        status;
   sched_stats_t                         stats;

   // reference model of queued events and in-flight work
   event_msg_t                 ref_q [$];
   logic [`PHOLD_LP_W-1:0]     init_lps [$];
   logic [`PHOLD_NUM_CORE-1:0] active;
   logic [`PHOLD_TIME_W-1:0]   flight_ts [`PHOLD_NUM_CORE];
   logic [`PHOLD_TIME_W-1:0]   last_gvt;
   logic                       done_prev;
   int                         disp_count;
   int                         anti_count;
   int                         tb_cycles;
   int                         phase;
   int                         errs [1:6];
   int                         passed;
   int                         failed;
   int                         total;
   integer                     seed;

   // core model state sampled at negedge and applied after posedge
   logic [`PHOLD_NUM_CORE-1:0] seen_disp;
   logic [`PHOLD_NUM_CORE-1:0] seen_ack;
   event_msg_t                 seen_msg;
   logic [`PHOLD_NUM_CORE-1:0] pending;
   logic [`PHOLD_TIME_W-1:0]   job_ts [`PHOLD_NUM_CORE];
   int                         wait_cnt [`PHOLD_NUM_CORE];
   logic                       run_seen;
   logic                       timed_out;

   phold_sched dut_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .sim_end         (sim_end),
      .num_init_events (num_init_events),
      .lp_mask         (lp_mask),
      .core_ready      (core_ready),
      .result_vld      (result_vld),
      .result_msg      (result_msg),
      .dispatch_vld    (dispatch_vld),
      .dispatch_msg    (dispatch_msg),
      .result_ack      (result_ack),
      .gvt             (gvt),
      .status          (status),
      .stats           (stats)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic logic is_null(input event_msg_t m);
      return m.anti && (m.lp == '0) && (m.ts == '0);
   endfunction

   // earlier time first and anti-message first on a tie
   function automatic logic sorts_before(input event_msg_t a, input event_msg_t b);
      return (a.ts < b.ts) || ((a.ts == b.ts) && a.anti && !b.anti);
   endfunction

   function automatic int test_index(input int k);
      return (phase == 2) ? 6 : k;
   endfunction

   task automatic lowest_pending(output logic found, output logic [`PHOLD_TIME_W-1:0] lo);
      found = 1'b0;
      lo    = '0;
      foreach (ref_q[i]) begin
         if (!found || ref_q[i].ts < lo) begin
            found = 1'b1;
            lo    = ref_q[i].ts;
         end
      end
      for (int c = 0; c < `PHOLD_NUM_CORE; c++) begin
         if (active[c] && (!found || flight_ts[c] < lo)) begin
            found = 1'b1;
            lo    = flight_ts[c];
         end
      end
   endtask

   task automatic check_dispatch();
      event_msg_t m;
      int         best;
      int         hit;
      int         lp_hit;
      m      = dispatch_msg;
      best   = -1;
      hit    = -1;
      lp_hit = -1;
      assert (((dispatch_vld & (dispatch_vld - 1'b1)) == '0)
              && ((dispatch_vld & ~core_ready) == '0)) else begin
         $display("dispatch pulse %b went to several cores or to a busy core", dispatch_vld);
         errs[test_index(2)] += 1;
      end
      assert (!is_null(m)) else begin
         $display("null message dispatched at %0t", $time);
         errs[test_index(2)] += 1;
      end
      assert (phase == 1) else begin
         $display("dispatch pulse at %0t during the overflow run", $time);
         errs[6] += 1;
      end
      foreach (ref_q[i]) begin
         if (best < 0 || sorts_before(ref_q[i], ref_q[best])) begin
            best = i;
         end
         if (hit < 0 && ref_q[i] == m) begin
            hit = i;
         end
      end
      if (best >= 0) begin
         assert (!sorts_before(ref_q[best], m) && !sorts_before(m, ref_q[best])) else begin
            $display("mismatch at %0t: dispatch_msg got %h, expected %h", $time, m, ref_q[best]);
            errs[test_index(2)] += 1;
         end
      end
      assert (hit >= 0) else begin
         $display("dispatched event %h was never queued", m);
         errs[test_index(2)] += 1;
      end
      if (hit >= 0) begin
         ref_q.delete(hit);
      end
      if (disp_count < num_init_events) begin
         assert (!m.anti && m.ts == '0) else begin
            $display("mismatch at %0t: dispatch_msg {anti,ts} got %h, expected 0", $time,
                     {m.anti, m.ts});
            errs[test_index(1)] += 1;
         end
         foreach (init_lps[i]) begin
            if (lp_hit < 0 && init_lps[i] == m.lp) begin
               lp_hit = i;
            end
         end
         assert (lp_hit >= 0) else begin
            $display("lp %0d is not among the remaining initial events", m.lp);
            errs[test_index(1)] += 1;
         end
         if (lp_hit >= 0) begin
            init_lps.delete(lp_hit);
         end
      end
      disp_count++;
      if (m.anti) begin
         anti_count++;
      end
      for (int c = 0; c < `PHOLD_NUM_CORE; c++) begin
         if (dispatch_vld[c]) begin
            active[c]    = 1'b1;
            flight_ts[c] = m.ts;
         end
      end
   endtask

   task automatic check_stats();
      int bound;
      // one idle cycle and two cycles per initial event come before running
      bound = tb_cycles - 2 * num_init_events - 1;
      assert (stats.events == disp_count) else begin
         $display("mismatch at %0t: stats.events got %0d, expected %0d", $time,
                  stats.events, disp_count);
         errs[5] += 1;
      end
      assert (stats.antimsgs == anti_count) else begin
         $display("mismatch at %0t: stats.antimsgs got %0d, expected %0d", $time,
                  stats.antimsgs, anti_count);
         errs[5] += 1;
      end
      assert (stats.cycles != 0 && stats.cycles <= bound) else begin
         $display("stats.cycles %0d is outside 1 to %0d", stats.cycles, bound);
         errs[5] += 1;
      end
      assert (!status.overflow) else begin
         $display("mismatch at %0t: status.overflow got 1, expected 0", $time);
         errs[4] += 1;
      end
   endtask

   task automatic check_cycle();
      logic                     found;
      logic [`PHOLD_TIME_W-1:0] lo;
      assert (gvt >= last_gvt) else begin
         $display("mismatch at %0t: gvt got %0d, expected at least %0d", $time, gvt, last_gvt);
         errs[test_index(3)] += 1;
      end
      lowest_pending(found, lo);
      if (found) begin
         assert (gvt <= lo) else begin
            $display("mismatch at %0t: gvt got %0d, expected at most %0d", $time, gvt, lo);
            errs[test_index(3)] += 1;
         end
      end
      assert (status.blocked == (gvt > sim_end)) else begin
         $display("mismatch at %0t: status.blocked got %0b, expected %0b", $time,
                  status.blocked, gvt > sim_end);
         errs[test_index(4)] += 1;
      end
      if (gvt > sim_end) begin
         assert (dispatch_vld == '0) else begin
            $display("dispatch pulse at %0t after gvt passed sim_end", $time);
            errs[test_index(4)] += 1;
         end
      end
      if (done_prev) begin
         assert (status.done) else begin
            $display("done dropped at %0t without a reset", $time);
            errs[test_index(4)] += 1;
         end
      end
      if (status.done && !done_prev) begin
         assert (active == '0) else begin
            $display("done rose at %0t while cores %b were active", $time, active);
            errs[test_index(4)] += 1;
         end
         if (phase == 1) begin
            check_stats();
         end
      end
   endtask

   always @(negedge clk) begin
      if (rst_n) begin
         if (!status.done) begin
            tb_cycles++;
         end
         check_cycle();
         if (|dispatch_vld) begin
            check_dispatch();
         end
         for (int c = 0; c < `PHOLD_NUM_CORE; c++) begin
            if (result_ack[c]) begin
               assert (result_vld[c]) else begin
                  $display("result_ack on core %0d without a held result", c);
                  errs[test_index(2)] += 1;
               end
               active[c] = 1'b0;
               if (!is_null(result_msg[c])) begin
                  ref_q.push_back(result_msg[c]);
               end
            end
         end
         seen_disp = dispatch_vld;
         seen_ack  = result_ack;
         seen_msg  = dispatch_msg;
         done_prev = status.done;
         last_gvt  = gvt;
      end else begin
         seen_disp = '0;
         seen_ack  = '0;
      end
   end

   // result kind 1 in 8 null, 1 in 8 anti, else positive
   task automatic present_result(input int c);
      logic [31:0] r;
      event_msg_t  m;
      r = $random(seed);
      if (r[2:0] == 3'd0) begin
         m = '{anti: 1'b1, lp: '0, ts: '0, pad: '0};
      end else begin
         m.anti = (r[2:0] == 3'd1);
         m.lp   = r[10:3] & lp_mask;
         m.ts   = job_ts[c] + `PHOLD_TIME_W'(r[13:11]) + 1'b1;
         m.pad  = '0;
      end
      result_msg[c] = m;
      result_vld[c] = 1'b1;
      pending[c]    = 1'b0;
   endtask

   // four core models
   always @(posedge clk) begin
      logic [31:0] r;
      run_seen = rst_n;
      #1;
      if (!run_seen) begin
         core_ready = '1;
         result_vld = '0;
         pending    = '0;
      end else begin
         for (int c = 0; c < `PHOLD_NUM_CORE; c++) begin
            if (seen_disp[c]) begin
               r             = $random(seed);
               core_ready[c] = 1'b0;
               job_ts[c]     = seen_msg.ts;
               wait_cnt[c]   = r[2:0] + 1;
               pending[c]    = 1'b1;
            end else if (seen_ack[c]) begin
               result_vld[c] = 1'b0;
               core_ready[c] = 1'b1;
            end else if (pending[c]) begin
               if (wait_cnt[c] > 1) begin
                  wait_cnt[c]--;
               end else begin
                  present_result(c);
               end
            end
         end
      end
   end

   task automatic apply_reset(input logic [`PHOLD_TIME_W-1:0] end_time, input int n_init,
                              input logic [`PHOLD_LP_W-1:0] mask);
      logic [`PHOLD_LP_W-1:0] lp;
      @(posedge clk);
      #1;
      rst_n           = 1'b0;
      sim_end         = end_time;
      num_init_events = 8'(n_init);
      lp_mask         = mask;
      ref_q.delete();
      init_lps.delete();
      active     = '0;
      disp_count = 0;
      anti_count = 0;
      tb_cycles  = 0;
      done_prev  = 1'b0;
      last_gvt   = '0;
      // initial event i targets lp i masked at time zero
      if (phase == 1) begin
         for (int i = 0; i < n_init; i++) begin
            lp = `PHOLD_LP_W'(i) & mask;
            ref_q.push_back('{anti: 1'b0, lp: lp, ts: '0, pad: '0});
            init_lps.push_back(lp);
         end
      end
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   task automatic wait_for_done(input int limit, output logic expired);
      int n;
      n = 0;
      while (!status.done && n < limit) begin
         @(negedge clk);
         n++;
      end
      expired = !status.done;
   endtask

   task automatic report_test(input int idx, input string name);
      if (errs[idx] == 0) begin
         $display("test %0d %s: ok", idx, name);
         passed++;
      end else begin
         $display("test %0d %s: failed with %0d errors", idx, name, errs[idx]);
         failed++;
      end
      total += errs[idx];
   endtask

   initial begin
      seed            = 79963;
      rst_n           = 1'b0;
      sim_end         = '0;
      num_init_events = '0;
      lp_mask         = '0;
      core_ready      = '1;
      result_vld      = '0;
      result_msg      = '0;
      seen_disp       = '0;
      seen_ack        = '0;
      pending         = '0;
      passed          = 0;
      failed          = 0;
      total           = 0;
      foreach (errs[i]) begin
         errs[i] = 0;
      end

      // main run where lp mask 7 repeats lps among the initial events
      phase = 1;
      apply_reset(16'd24, 12, 8'h07);
      wait_for_done(20000, timed_out);
      if (timed_out) begin
         $display("timeout waiting for done in the main run");
         errs[4] += 1;
      end
      repeat (20) @(negedge clk);
      assert (init_lps.size() == 0) else begin
         $display("%0d initial events were never dispatched", init_lps.size());
         errs[1] += 1;
      end
      report_test(1, "initial events");
      report_test(2, "dispatch order");
      report_test(3, "gvt bounds");
      report_test(4, "termination");
      report_test(5, "statistics");

      // more initial events than queue entries
      phase = 2;
      apply_reset(16'd24, 20, 8'hff);
      wait_for_done(2000, timed_out);
      if (timed_out) begin
         $display("timeout waiting for done in the overflow run");
         errs[6] += 1;
      end
      assert (status.overflow) else begin
         $display("mismatch at %0t: status.overflow got 0, expected 1", $time);
         errs[6] += 1;
      end
      repeat (5) @(negedge clk);
      report_test(6, "queue overflow");

      $display("%0d tests passed, %0d failed, %0d errors", passed, failed, total);
      if (failed == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/phold_pkg.sv
verilog/rr_arbiter.sv
verilog/event_queue.sv
verilog/event_dispatch.sv
verilog/gvt_tracker.sv
verilog/sim_control.sv
verilog/phold_sched.sv
tb/tb_phold_sched.sv
